//--- rr_switch_alloc.f
rr_port_pkg.sv
rr_flit_pkg.sv
rr_request_decoder.sv
rr_priority_ring.sv
rr_grant_encoder.sv
rr_port_arbiter.sv
rr_crossbar.sv
rr_switch_alloc_top.sv
rr_switch_alloc_tb.sv

//--- rr_switch_alloc_tb.sv
/*
  Testbench for the switch allocation and crossbar stage
  - galois lfsr as the only random source, fixed seed
  - packet sources for the five inputs, 1 to 3 flits per packet
  - reference model with a pointer and a wormhole lock per output
  - value check task and watchdog
*/
`timescale 1ns/10ps
`default_nettype none

module rr_switch_alloc_tb
  import rr_port_pkg::*;
  import rr_flit_pkg::*;
();

  localparam int          CLK_PERIOD    = 100;
  localparam int          RESET_CYCLES  = 5;
  localparam int          RUN_CYCLES    = 3000;
  localparam int          MARGIN_CYCLES = 100;
  localparam logic [31:0] LFSR_SEED     = 32'h6803;
  localparam logic [31:0] LFSR_TAPS     = 32'h80200003;

  logic                  clk;
  logic                  rst_n_i;
  flit_t [NUM_PORTS-1:0] in_flit_i;
  port_vec_t             out_ready_i;
  flit_t [NUM_PORTS-1:0] out_flit_o;
  port_vec_t             in_grant_o;

  logic [31:0] lfsr_q;

  // source state, one entry per input
  flit_t src_flit [NUM_PORTS];
  int    src_left [NUM_PORTS];
  int    src_gap  [NUM_PORTS];
  int    src_nh   [NUM_PORTS];

  // model state, one entry per output
  int        mdl_ptr   [NUM_PORTS];
  logic      mdl_lock  [NUM_PORTS];
  int        mdl_owner [NUM_PORTS];
  int        exp_sel   [NUM_PORTS];
  port_vec_t exp_grant;

  int sent_cnt;
  int delivered_cnt;
  int parallel_cycles;

  rr_switch_alloc_top i_rr_switch_alloc_top (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_flit_i   (in_flit_i),
    .out_ready_i (out_ready_i),
    .out_flit_o  (out_flit_o),
    .in_grant_o  (in_grant_o)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic start_packet(input int p);
    flit_t f;
    f           = '0;
    src_left[p] = 1 + int'(rand_bits(2)) % 3;
    // one of the four other ports, never back out the arrival side
    src_nh[p]   = (p + 1 + int'(rand_bits(2))) % NUM_PORTS;
    f.valid     = 1'b1;
    f.head      = 1'b1;
    f.tail      = (src_left[p] == 1);
    f.data.head.nexthop = port_e'(src_nh[p]);
    f.data.head.dst_x   = 2'(rand_bits(2));
    f.data.head.dst_y   = 2'(rand_bits(2));
    f.data.head.tag     = 9'(rand_bits(9));
    src_flit[p] = f;
  endtask

  task automatic next_body_flit(input int p);
    flit_t f;
    f       = '0;
    f.valid = 1'b1;
    f.tail  = (src_left[p] == 1);
    f.data.body.payload = 16'(rand_bits(16));
    src_flit[p] = f;
  endtask

  // round-robin from the pointer, or the owner while a packet is in flight
  task automatic predict_grants();
    int    idx;
    flit_t f;
    exp_grant = '0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      exp_sel[o] = -1;
      if (mdl_lock[o]) begin
        if (src_flit[mdl_owner[o]].valid) begin
          exp_sel[o] = mdl_owner[o];
        end
      end else begin
        for (int k = 0; k < NUM_PORTS; k++) begin
          idx = (mdl_ptr[o] + k) % NUM_PORTS;
          f   = src_flit[idx];
          if (exp_sel[o] < 0 && idx != o && f.valid && f.head &&
              int'(f.data.head.nexthop) == o) begin
            exp_sel[o] = idx;
          end
        end
      end
      if (exp_sel[o] >= 0 && out_ready_i[o]) begin
        exp_grant[exp_sel[o]] = 1'b1;
      end
    end
  endtask

  task automatic check_outputs();
    for (int o = 0; o < NUM_PORTS; o++) begin
      check_value($sformatf("out_flit_o[%0d].valid", o), 32'(out_flit_o[o].valid),
                  32'(exp_sel[o] >= 0));
      if (exp_sel[o] >= 0) begin
        check_value($sformatf("out_flit_o[%0d]", o), 32'(out_flit_o[o]),
                    32'(src_flit[exp_sel[o]]));
      end
    end
    check_value("in_grant_o", 32'(in_grant_o), 32'(exp_grant));
  endtask

  task automatic apply_transfers();
    int    sel;
    int    xfers;
    flit_t f;
    xfers = 0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      // transfers as seen at the DUT outputs
      if (out_flit_o[o].valid && out_ready_i[o]) begin
        delivered_cnt++;
        if (out_flit_o[o].head) begin
          check_value($sformatf("out_flit_o[%0d].data.head.nexthop", o),
                      32'(out_flit_o[o].data.head.nexthop), o);
        end
      end
      if (exp_sel[o] >= 0 && out_ready_i[o]) begin
        sel = exp_sel[o];
        f   = src_flit[sel];
        xfers++;
        if (f.tail) begin
          mdl_lock[o] = 1'b0;
          mdl_ptr[o]  = (sel + 1) % NUM_PORTS;
        end else if (f.head) begin
          mdl_lock[o]  = 1'b1;
          mdl_owner[o] = sel;
        end
      end
    end
    if (xfers > 1) begin
      parallel_cycles++;
    end
  endtask

  // idle gaps only between packets
  task automatic advance_sources();
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (src_flit[p].valid && exp_grant[p]) begin
        sent_cnt++;
        src_left[p]--;
        if (src_left[p] > 0) begin
          next_body_flit(p);
        end else if (rand_bits(1) != 0) begin
          start_packet(p);
        end else begin
          src_flit[p] = '0;
          src_gap[p]  = int'(rand_bits(2));
        end
      end else if (!src_flit[p].valid) begin
        if (src_gap[p] == 0) begin
          start_packet(p);
        end else begin
          src_gap[p]--;
        end
      end
    end
  endtask

  initial begin : main
    clk             = 1'b0;
    rst_n_i         = 1'b0;
    in_flit_i       = '0;
    out_ready_i     = '1;
    lfsr_q          = LFSR_SEED;
    sent_cnt        = 0;
    delivered_cnt   = 0;
    parallel_cycles = 0;
    exp_grant       = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      src_flit[p]  = '0;
      src_left[p]  = 0;
      src_gap[p]   = 1;
      src_nh[p]    = 0;
      mdl_ptr[p]   = int'(N);
      mdl_lock[p]  = 1'b0;
      mdl_owner[p] = 0;
      exp_sel[p]   = -1;
    end

    // idle inputs in reset, nothing may show up
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      for (int o = 0; o < NUM_PORTS; o++) begin
        check_value($sformatf("out_flit_o[%0d].valid", o), 32'(out_flit_o[o].valid), 0);
      end
      check_value("in_grant_o", 32'(in_grant_o), 0);
    end
    rst_n_i = 1'b1;

    for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
      @(negedge clk);
      for (int p = 0; p < NUM_PORTS; p++) begin
        in_flit_i[p] = src_flit[p];
      end
      // ready about three cycles in four
      for (int o = 0; o < NUM_PORTS; o++) begin
        out_ready_i[o] = |rand_bits(2);
      end
      #(CLK_PERIOD/10);
      predict_grants();
      check_outputs();
      apply_transfers();
      advance_sources();
    end

    check_value("flits delivered", delivered_cnt, sent_cnt);
    check_value("cycles with parallel transfers seen", 32'(parallel_cycles > 0), 1);
    $display("%0d flits delivered, %0d cycles with parallel transfers",
             delivered_cnt, parallel_cycles);
    $display("Simulation finished: PASS");
    $finish;
  end

  initial begin : watchdog
    #((RESET_CYCLES + RUN_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("watchdog expired, the run did not finish within %0d cycles",
             RESET_CYCLES + RUN_CYCLES + MARGIN_CYCLES);
    $display("Simulation finished: FAIL");
    $fatal(1, "timeout");
  end

endmodule : rr_switch_alloc_tb

`default_nettype wire

//--- rr_switch_alloc_top.sv
/*
  Switch allocation and crossbar stage of a five-port mesh router
  - one round-robin arbiter per output port
  - crossbar steered by the arbiter select codes
  - per-input grant merged from all outputs and their readies
*/
`timescale 1ns/10ps
`default_nettype none

module rr_switch_alloc_top
  import rr_port_pkg::*;
  import rr_flit_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  flit_t [NUM_PORTS-1:0] in_flit_i,
  input  port_vec_t             out_ready_i,
  output flit_t [NUM_PORTS-1:0] out_flit_o,
  output port_vec_t             in_grant_o
);

  // indexed by output port
  port_vec_t [NUM_PORTS-1:0] arb_grant;
  port_e     [NUM_PORTS-1:0] arb_sel;
  port_vec_t                 arb_valid;

  // same grants, indexed by input port
  port_vec_t [NUM_PORTS-1:0] grant_by_in;

  for (genvar o = 0; o < NUM_PORTS; o++) begin : g_arb
    rr_port_arbiter #(
      .OUT_PORT (port_e'(o))
    ) i_rr_port_arbiter (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .in_flit_i   (in_flit_i),
      .out_ready_i (out_ready_i[o]),
      .grant_o     (arb_grant[o]),
      .sel_o       (arb_sel[o]),
      .out_valid_o (arb_valid[o])
    );
  end

  rr_crossbar i_rr_crossbar (
    .in_flit_i  (in_flit_i),
    .sel_i      (arb_sel),
    .valid_i    (arb_valid),
    .out_flit_o (out_flit_o)
  );

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        grant_by_in[p][o] = arb_grant[o][p];
      end
    end
  end

  // input is taken only when its output accepts the flit
  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      in_grant_o[p] = |(grant_by_in[p] & out_ready_i);
    end
  end

  // each head flit names one output, so two arbiters never share an input
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_chk
    a_single_output : assert property (
      @(posedge clk) disable iff (!rst_n_i)
      $onehot0(grant_by_in[p])
    ) else $error("input granted by more than one output");
  end

endmodule : rr_switch_alloc_top

`default_nettype wire

//--- rr_crossbar.sv
/*
  Five-to-five flit crossbar
  - one mux per output, steered by the arbiter select code
  - valid bit masked so an idle output shows no flit
*/
`timescale 1ns/10ps
`default_nettype none

module rr_crossbar
  import rr_port_pkg::*;
  import rr_flit_pkg::*;
(
  input  flit_t [NUM_PORTS-1:0] in_flit_i,
  input  port_e [NUM_PORTS-1:0] sel_i,
  input  port_vec_t             valid_i,
  output flit_t [NUM_PORTS-1:0] out_flit_o
);

  flit_t mux_flit;

  always_comb begin
    mux_flit   = '0;
    out_flit_o = '0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      mux_flit       = in_flit_i[sel_i[o]];
      // payload may be stale when idle, valid is what matters
      mux_flit.valid = mux_flit.valid && valid_i[o];
      out_flit_o[o]  = mux_flit;
    end
  end

endmodule : rr_crossbar

`default_nettype wire

//--- rr_port_arbiter.sv
/*
  Switch arbiter for one output port
  - request decoder, priority ring and grant encoder
  - wormhole lock and owner register for multi-flit packets
  - transfer event is valid and ready in the same cycle
*/
`timescale 1ns/10ps
`default_nettype none

module rr_port_arbiter
  import rr_port_pkg::*;
  import rr_flit_pkg::*;
#(
  parameter port_e OUT_PORT = N
) (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  flit_t [NUM_PORTS-1:0] in_flit_i,
  input  logic                  out_ready_i,
  output port_vec_t             grant_o,
  output port_e                 sel_o,
  output logic                  out_valid_o
);

  port_vec_t req;
  port_vec_t ptr;
  logic      lock_q;
  port_e     owner_q;
  logic      owner_valid;
  flit_t     win_flit;
  logic      xfer;
  logic      xfer_tail;

  rr_request_decoder #(
    .OUT_PORT (OUT_PORT)
  ) i_rr_request_decoder (
    .in_flit_i (in_flit_i),
    .req_o     (req)
  );

  rr_priority_ring i_rr_priority_ring (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .advance_i (xfer_tail),
    .served_i  (grant_o),
    .ptr_o     (ptr)
  );

  rr_grant_encoder i_rr_grant_encoder (
    .req_i         (req),
    .ptr_i         (ptr),
    .lock_i        (lock_q),
    .owner_i       (owner_q),
    .owner_valid_i (owner_valid),
    .grant_o       (grant_o),
    .sel_o         (sel_o)
  );

  assign owner_valid = in_flit_i[owner_q].valid;
  assign win_flit    = in_flit_i[sel_o];
  assign out_valid_o = |grant_o;

  assign xfer      = out_valid_o && out_ready_i;
  // pointer only moves once the whole packet has passed
  assign xfer_tail = xfer && win_flit.tail;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q  <= 1'b0;
      owner_q <= N;
    end else if (xfer) begin
      if (!lock_q && win_flit.head && !win_flit.tail) begin
        lock_q  <= 1'b1;
        owner_q <= sel_o;
      end else if (lock_q && win_flit.tail) begin
        lock_q  <= 1'b0;
      end
    end
  end

  // a locked output only carries the rest of the owner's packet
  a_locked_no_head : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    (lock_q && xfer) |-> !win_flit.head
  ) else $error("new head flit passed through a locked output");

endmodule : rr_port_arbiter

`default_nettype wire

//--- rr_grant_encoder.sv
/*
  Grant encoder for one output port
  - locked: grants the owner when its flit is valid
  - unlocked: cyclic scan from the pointer, first requester wins
  - one-hot grant plus the port code for the crossbar select
*/
`timescale 1ns/10ps
`default_nettype none

module rr_grant_encoder
  import rr_port_pkg::*;
(
  input  port_vec_t req_i,
  input  port_vec_t ptr_i,
  input  logic      lock_i,
  input  port_e     owner_i,
  input  logic      owner_valid_i,
  output port_vec_t grant_o,
  output port_e     sel_o
);

  always_comb begin
    int unsigned start;
    int unsigned idx;
    logic        found;

    start   = 0;
    idx     = 0;
    found   = 1'b0;
    grant_o = '0;
    sel_o   = N;

    // pointer is one-hot, turn it into a start index
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (ptr_i[p]) begin
        start = p;
      end
    end

    if (lock_i) begin
      // wormhole in progress, nobody else gets in
      if (owner_valid_i) begin
        grant_o[owner_i] = 1'b1;
        sel_o            = owner_i;
      end
    end else begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        idx = start + i;
        if (idx >= NUM_PORTS) begin
          idx = idx - NUM_PORTS;
        end
        if (!found && req_i[idx]) begin
          found        = 1'b1;
          grant_o[idx] = 1'b1;
          sel_o        = port_e'(idx);
        end
      end
    end
  end

endmodule : rr_grant_encoder

`default_nettype wire

//--- rr_priority_ring.sv
/*
  Round-robin priority pointer for one output port
  - one-hot pointer, bit 0 (north) after reset
  - on advance_i moves to the position just after served_i
  - wraps from local back to north
*/
`timescale 1ns/10ps
`default_nettype none

module rr_priority_ring
  import rr_port_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      advance_i,
  input  port_vec_t served_i,
  output port_vec_t ptr_o
);

  port_vec_t ptr_q;
  port_vec_t ptr_next;

  // rotate the served position left by one, top bit wraps to north
  assign ptr_next = {served_i[NUM_PORTS-2:0], served_i[NUM_PORTS-1]};

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= port_vec_t'(1) << N;
    end else if (advance_i) begin
      ptr_q <= ptr_next;
    end
  end

  assign ptr_o = ptr_q;

  // pointer never loses or duplicates its token
  a_ptr_onehot : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    $onehot(ptr_o)
  ) else $error("priority pointer is not one-hot");

  // arbiter only advances on a real single grant
  a_served_onehot : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    advance_i |-> $onehot(served_i)
  ) else $error("advance with served vector not one-hot");

endmodule : rr_priority_ring

`default_nettype wire

//--- rr_request_decoder.sv
/*
  Request decoder for one output port
  - looks at the flit waiting at every input
  - raises a request for each valid head flit routed to OUT_PORT
  - the input on the same side as the output never requests
*/
`timescale 1ns/10ps
`default_nettype none

module rr_request_decoder
  import rr_port_pkg::*;
  import rr_flit_pkg::*;
#(
  parameter port_e OUT_PORT = N
) (
  input  flit_t [NUM_PORTS-1:0] in_flit_i,
  output port_vec_t             req_o
);

  logic  is_route;
  logic  is_uturn;
  flit_t cur_flit;

  always_comb begin
    req_o    = '0;
    is_route = 1'b0;
    is_uturn = 1'b0;
    cur_flit = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      cur_flit = in_flit_i[p];
      // nexthop is only read through the head view
      is_route = (cur_flit.data.head.nexthop == OUT_PORT);
      // no u-turn back out of the arrival port
      is_uturn = (port_e'(p) == OUT_PORT);
      // body flits never request, they follow the lock
      req_o[p] = cur_flit.valid && cur_flit.head && is_route && !is_uturn;
    end
  end

endmodule : rr_request_decoder

`default_nettype wire

//--- rr_flit_pkg.sv
/*
  Flit layout for the switch allocation stage
  - FLIT_DATA_W  width of the flit data word
  - flit_head_t  head view of the data word, carries the route
  - flit_body_t  body view of the data word, plain payload
  - flit_data_u  union of both views
  - flit_t       valid, head and tail bits plus the data word
*/
`default_nettype none

package rr_flit_pkg;

  import rr_port_pkg::*;

  localparam int FLIT_DATA_W = 16;

  // route info, only meaningful on head flits
  typedef struct packed {
    port_e      nexthop;
    logic [1:0] dst_x;
    logic [1:0] dst_y;
    logic [8:0] tag;
  } flit_head_t;

  typedef struct packed {
    logic [FLIT_DATA_W-1:0] payload;
  } flit_body_t;

  // same word, decoded as route or as payload depending on the head bit
  typedef union packed {
    flit_head_t head;
    flit_body_t body;
  } flit_data_u;

  // single-flit packet has head and tail both set
  typedef struct packed {
    logic       valid;
    logic       head;
    logic       tail;
    flit_data_u data;
  } flit_t;

endpackage : rr_flit_pkg

`default_nettype wire

//--- rr_port_pkg.sv
/*
  Router port definitions for the switch allocation stage
  - port_e      port codes of the five-port mesh router
  - NUM_PORTS   number of router ports
  - port_vec_t  one bit per port, indexed by port_e
*/
`default_nettype none

package rr_port_pkg;

  // fixed for a 2d mesh router with one local port
  localparam int NUM_PORTS = 5;

  // port codes, also used as select codes for the crossbar
  typedef enum logic [2:0] {
    N = 3'd0,
    S = 3'd1,
    W = 3'd2,
    E = 3'd3,
    L = 3'd4
  } port_e;

  // requests, grants, pointers, valids and readies
  typedef logic [NUM_PORTS-1:0] port_vec_t;

endpackage : rr_port_pkg

`default_nettype wire
